// File: source/bus_pkg.sv
// Request and response types shared by the memory bus master, interconnect and targets.
// Import into any module that carries bus_req_t or bus_rsp_t on its ports.

package bus_pkg;

	// ******************************
	// Bus widths
	// ******************************
	localparam int DATA_W = 32;			// Data word width
	localparam int ID_W   = 4;			// Requester ID width
	localparam int ADDR_W = 32;			// Byte address width
	localparam int STRB_W = DATA_W / 8;	// One strobe per byte lane

	// Response codes follow the AXI encoding
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_DECERR = 2'b11
	} resp_t;

	// ******************************
	// Channel payloads
	// ******************************
	typedef struct packed {
		logic [ADDR_W-1:0] addr;	// Byte address
		logic [DATA_W-1:0] wdata;	// Write data ignored on reads
		logic [STRB_W-1:0] wstrb;	// Byte strobes ignored on reads
		logic              write;	// 1 = write, 0 = read
		logic [ID_W-1:0]   id;		// Requester ID
	} bus_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;	// Read data or zero for writes and errors
		resp_t             resp;	// Completion status
		logic              write;	// Echo of the request type
		logic [ID_W-1:0]   id;		// Echo of the requester ID
	} bus_rsp_t;

endpackage

// File: source/mem_map_pkg.sv
// Address map defaults and target selection type for the memory fabric.
// The top level takes its parameter defaults from here.

package mem_map_pkg;

	// ******************************
	// Target selection
	// ******************************
	typedef enum logic {
		TGT_SRAM = 1'b0,	// Request falls in the SRAM window
		TGT_ERR  = 1'b1		// Anything else
	} target_sel_t;

	// ******************************
	// Default SRAM window
	// ******************************
	localparam logic [31:0] SRAM_BASE_DEF = 32'h0000_1000;	// First byte of the SRAM
	localparam int SRAM_ADDR_BITS_DEF = 10;					// log2 of size in bytes (1 KiB)

	// The window covers SRAM_BASE_DEF up to SRAM_BASE_DEF + 2**SRAM_ADDR_BITS_DEF - 1.
	// The base is expected to be aligned to the window size.

endpackage

// File: source/bus_interconnect_1x2.sv
// One master to two targets with address decode on the request path and an in-order
// route FIFO that picks which target's response goes back to the master.

module bus_interconnect_1x2
	import bus_pkg::*;
	import mem_map_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SRAM_BASE      = SRAM_BASE_DEF,
	parameter int                SRAM_ADDR_BITS = SRAM_ADDR_BITS_DEF,
	parameter int                ROUTE_DEPTH    = 4
) (
	input  logic     clk,
	input  logic     i_rst_n,

	// Master side
	input  logic     i_req_valid,
	input  bus_req_t i_req,
	output logic     o_req_ready,
	output logic     o_rsp_valid,
	output bus_rsp_t o_rsp,
	input  logic     i_rsp_ready,

	// SRAM target side
	output logic     o_sram_req_valid,
	output bus_req_t o_sram_req,
	input  logic     i_sram_req_ready,
	input  logic     i_sram_rsp_valid,
	input  bus_rsp_t i_sram_rsp,
	output logic     o_sram_rsp_ready,

	// Decode-error target side
	output logic     o_err_req_valid,
	output bus_req_t o_err_req,
	input  logic     i_err_req_ready,
	input  logic     i_err_rsp_valid,
	input  bus_rsp_t i_err_rsp,
	output logic     o_err_rsp_ready
);

	localparam int PTR_W = (ROUTE_DEPTH > 1) ? $clog2(ROUTE_DEPTH) : 1;
	localparam int CNT_W = $clog2(ROUTE_DEPTH + 1);

	logic [ADDR_W-1:0] req_offset;
	target_sel_t       req_sel;
	target_sel_t       head_sel;
	logic              req_push;
	logic              rsp_pop;
	logic              fifo_full;
	logic              fifo_empty;

	target_sel_t       route_mem [ROUTE_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	// ******************************
	// Request path
	// ******************************
	// Offset wraps below the base, so the lower bound is checked on its own
	assign req_offset = i_req.addr - SRAM_BASE;
	assign req_sel    = ((i_req.addr >= SRAM_BASE) &&
	                     (req_offset[ADDR_W-1:SRAM_ADDR_BITS] == '0)) ? TGT_SRAM : TGT_ERR;

	assign o_sram_req       = i_req;
	assign o_err_req        = i_req;
	assign o_sram_req_valid = i_req_valid && !fifo_full && (req_sel == TGT_SRAM);
	assign o_err_req_valid  = i_req_valid && !fifo_full && (req_sel == TGT_ERR);

	assign o_req_ready = !fifo_full &&
	                     ((req_sel == TGT_SRAM) ? i_sram_req_ready : i_err_req_ready);
	assign req_push    = i_req_valid && o_req_ready;

	// ******************************
	// Response path
	// ******************************
	assign head_sel    = route_mem[rd_ptr];
	assign o_rsp       = (head_sel == TGT_SRAM) ? i_sram_rsp : i_err_rsp;
	assign o_rsp_valid = !fifo_empty &&
	                     ((head_sel == TGT_SRAM) ? i_sram_rsp_valid : i_err_rsp_valid);

	assign o_sram_rsp_ready = i_rsp_ready && !fifo_empty && (head_sel == TGT_SRAM);
	assign o_err_rsp_ready  = i_rsp_ready && !fifo_empty && (head_sel == TGT_ERR);
	assign rsp_pop          = o_rsp_valid && i_rsp_ready;

	// ******************************
	// Route FIFO
	// ******************************
	assign fifo_full  = (count == CNT_W'(ROUTE_DEPTH));
	assign fifo_empty = (count == '0);

	always_ff @(posedge clk) begin
		if (req_push) begin
			route_mem[wr_ptr] <= req_sel;	// Remember where this request went
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(ROUTE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rsp_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(ROUTE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({req_push, rsp_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or push and pop together
			endcase
		end
	end

endmodule

// File: source/sram_target.sv
// Word-wide SRAM target with byte-strobe writes and a registered response.
// Sits behind the interconnect on the SRAM window of the address map.

module sram_target
	import bus_pkg::*;
	import mem_map_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SRAM_BASE      = SRAM_BASE_DEF,
	parameter int                SRAM_ADDR_BITS = SRAM_ADDR_BITS_DEF
) (
	input  logic     clk,
	input  logic     i_rst_n,

	// Request channel
	input  logic     i_req_valid,
	input  bus_req_t i_req,
	output logic     o_req_ready,

	// Response channel
	output logic     o_rsp_valid,
	output bus_rsp_t o_rsp,
	input  logic     i_rsp_ready
);

	localparam int MEM_WORDS = (2 ** SRAM_ADDR_BITS) / 4;

	logic [DATA_W-1:0]         mem [MEM_WORDS];
	logic [ADDR_W-1:0]         req_offset;
	logic [SRAM_ADDR_BITS-3:0] word_idx;
	logic [DATA_W-1:0]         rd_word;
	logic                      req_fire;

	logic                      rsp_valid_q;
	bus_rsp_t                  rsp_q;

	// ******************************
	// Handshake
	// ******************************
	// A new request is taken when the slot is free or is being emptied now
	assign o_req_ready = !rsp_valid_q || i_rsp_ready;
	assign req_fire    = i_req_valid && o_req_ready;

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp       = rsp_q;

	// ******************************
	// Memory array
	// ******************************
	assign req_offset = i_req.addr - SRAM_BASE;
	assign word_idx   = req_offset[SRAM_ADDR_BITS-1:2];	// Byte lane bits dropped
	assign rd_word    = mem[word_idx];					// Old contents on read-write clash

	always_ff @(posedge clk) begin
		if (req_fire && i_req.write) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (i_req.wstrb[b]) begin
					mem[word_idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
				end
			end
		end
	end

	// ******************************
	// Response register
	// ******************************
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rsp_valid_q <= 1'b0;
		end else if (req_fire) begin
			rsp_valid_q <= 1'b1;
		end else if (i_rsp_ready) begin
			rsp_valid_q <= 1'b0;	// Taken with nothing new behind it
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			rsp_q.rdata <= i_req.write ? '0 : rd_word;	// Writes answer with zero data
			rsp_q.resp  <= RESP_OKAY;
			rsp_q.write <= i_req.write;
			rsp_q.id    <= i_req.id;
		end
	end

endmodule

// File: source/decode_err_target.sv
// Default target for addresses outside every window.
// Answers each request with DECERR and zero data one cycle later.

module decode_err_target
	import bus_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst_n,
	input  logic     i_req_valid,
	input  bus_req_t i_req,
	output logic     o_req_ready,
	output logic     o_rsp_valid,
	output bus_rsp_t o_rsp,
	input  logic     i_rsp_ready
);

	logic     req_fire;
	logic     rsp_valid_q;
	bus_rsp_t rsp_q;

	assign o_req_ready = !rsp_valid_q || i_rsp_ready;	// Same slot rule as the SRAM
	assign req_fire    = i_req_valid && o_req_ready;
	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp       = rsp_q;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rsp_valid_q <= 1'b0;
		end else if (req_fire) begin
			rsp_valid_q <= 1'b1;
		end else if (i_rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	// Write data and strobes are dropped and only ID and type come back
	always_ff @(posedge clk) begin
		if (req_fire) begin
			rsp_q.rdata <= '0;
			rsp_q.resp  <= RESP_DECERR;
			rsp_q.write <= i_req.write;
			rsp_q.id    <= i_req.id;
		end
	end

endmodule

// File: source/mem_fabric_top.sv
// Memory fabric top level with the interconnect, an SRAM target and a decode-error target.
// The external master drives the request channel and takes responses in order.

module mem_fabric_top
	import bus_pkg::*;
	import mem_map_pkg::*;
#(
	parameter logic [ADDR_W-1:0] SRAM_BASE      = SRAM_BASE_DEF,
	parameter int                SRAM_ADDR_BITS = SRAM_ADDR_BITS_DEF,
	parameter int                ROUTE_DEPTH    = 4		// Max requests in flight
) (
	input  logic     clk,
	input  logic     i_rst_n,
	input  logic     i_req_valid,
	input  bus_req_t i_req,
	output logic     o_req_ready,
	output logic     o_rsp_valid,
	output bus_rsp_t o_rsp,
	input  logic     i_rsp_ready
);

	// ******************************
	// Interconnect to target wires
	// ******************************
	logic     sram_req_valid;
	logic     sram_req_ready;
	logic     sram_rsp_valid;
	logic     sram_rsp_ready;
	bus_req_t sram_req;
	bus_rsp_t sram_rsp;
	logic     err_req_valid;
	logic     err_req_ready;
	logic     err_rsp_valid;
	logic     err_rsp_ready;
	bus_req_t err_req;
	bus_rsp_t err_rsp;

	bus_interconnect_1x2 #(
		.SRAM_BASE        (SRAM_BASE     ),
		.SRAM_ADDR_BITS   (SRAM_ADDR_BITS),
		.ROUTE_DEPTH      (ROUTE_DEPTH   )
	) i_bus_interconnect_1x2 (
		.clk              (clk           ),
		.i_rst_n          (i_rst_n       ),
		.i_req_valid      (i_req_valid   ),
		.i_req            (i_req         ),
		.o_req_ready      (o_req_ready   ),
		.o_rsp_valid      (o_rsp_valid   ),
		.o_rsp            (o_rsp         ),
		.i_rsp_ready      (i_rsp_ready   ),
		.o_sram_req_valid (sram_req_valid),
		.o_sram_req       (sram_req      ),
		.i_sram_req_ready (sram_req_ready),
		.i_sram_rsp_valid (sram_rsp_valid),
		.i_sram_rsp       (sram_rsp      ),
		.o_sram_rsp_ready (sram_rsp_ready),
		.o_err_req_valid  (err_req_valid ),
		.o_err_req        (err_req       ),
		.i_err_req_ready  (err_req_ready ),
		.i_err_rsp_valid  (err_rsp_valid ),
		.i_err_rsp        (err_rsp       ),
		.o_err_rsp_ready  (err_rsp_ready )
	);

	sram_target #(
		.SRAM_BASE      (SRAM_BASE     ),
		.SRAM_ADDR_BITS (SRAM_ADDR_BITS)
	) i_sram_target (
		.clk            (clk           ),
		.i_rst_n        (i_rst_n       ),
		.i_req_valid    (sram_req_valid),
		.i_req          (sram_req      ),
		.o_req_ready    (sram_req_ready),
		.o_rsp_valid    (sram_rsp_valid),
		.o_rsp          (sram_rsp      ),
		.i_rsp_ready    (sram_rsp_ready)
	);

	decode_err_target i_decode_err_target (
		.clk         (clk          ),
		.i_rst_n     (i_rst_n      ),
		.i_req_valid (err_req_valid),
		.i_req       (err_req      ),
		.o_req_ready (err_req_ready),
		.o_rsp_valid (err_rsp_valid),
		.o_rsp       (err_rsp      ),
		.i_rsp_ready (err_rsp_ready)
	);

endmodule

// File: bench/mem_fabric_tb.sv
// Testbench for the memory fabric that plays the bus master on the request channel
// and checks every response against a reference model of the address map and SRAM.

module mem_fabric_tb
	import bus_pkg::*;
	import mem_map_pkg::*;
();

	localparam int          ROUTE_DEPTH    = 4;	// Matches the top level default
	localparam logic [31:0] SRAM_BASE      = SRAM_BASE_DEF;
	localparam logic [31:0] SRAM_END       = SRAM_BASE_DEF + (32'd1 << SRAM_ADDR_BITS_DEF);
	localparam int          SRAM_WORDS     = (1 << SRAM_ADDR_BITS_DEF) / 4;
	localparam int          N_WORDS        = 16;
	localparam int          N_ERR          = 16;
	localparam int          N_RAND         = 200;
	localparam int          TOTAL_REQS     = 5 * N_WORDS + N_ERR + 2 * N_RAND;
	localparam int          TIMEOUT_CYCLES = TOTAL_REQS * 20 + 1000;

	logic     clk;
	logic     i_rst_n;
	logic     i_req_valid;
	bus_req_t i_req;
	logic     o_req_ready;
	logic     o_rsp_valid;
	bus_rsp_t o_rsp;
	logic     i_rsp_ready;

	logic [DATA_W-1:0] model_mem [logic [29:0]];	// Keyed by word address
	bus_rsp_t          exp_q [$];					// Expected responses in order
	logic [31:0]       known_q [$];					// SRAM words with defined contents
	int                errors   = 0;
	int                n_checks = 0;
	int                n_reqs   = 0;
	bit                stall_en = 1'b0;

	mem_fabric_top i_mem_fabric_top (
		.clk         (clk        ),
		.i_rst_n     (i_rst_n    ),
		.i_req_valid (i_req_valid),
		.i_req       (i_req      ),
		.o_req_ready (o_req_ready),
		.o_rsp_valid (o_rsp_valid),
		.o_rsp       (o_rsp      ),
		.i_rsp_ready (i_rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ******************************
	// Reference model
	// ******************************
	function automatic bus_rsp_t ref_rsp(bus_req_t r);
		bus_rsp_t          e;
		logic [DATA_W-1:0] w;
		e.id    = r.id;
		e.write = r.write;
		e.rdata = '0;
		if (r.addr < SRAM_BASE || r.addr >= SRAM_END) begin
			e.resp = RESP_DECERR;	// Outside the window the memory is untouched
		end else begin
			e.resp = RESP_OKAY;
			w = model_mem.exists(r.addr[31:2]) ? model_mem[r.addr[31:2]] : 'x;
			if (r.write) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (r.wstrb[b]) w[b*8 +: 8] = r.wdata[b*8 +: 8];
				end
				model_mem[r.addr[31:2]] = w;
			end else begin
				e.rdata = w;
			end
		end
		return e;
	endfunction

	// ******************************
	// Checks
	// ******************************
	task automatic report_fail(string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic check_rsp(bus_rsp_t got, bus_rsp_t exp);
		n_checks++;
		if (got !== exp) begin
			report_fail($sformatf("got/exp id %0h/%0h wr %b/%b resp %0d/%0d data %08h/%08h",
				got.id, exp.id, got.write, exp.write, got.resp, exp.resp,
				got.rdata, exp.rdata));
		end
	endtask

	task automatic check_ready(bit exp);
		if (o_req_ready !== exp) begin
			report_fail($sformatf("o_req_ready is %b, expected %b", o_req_ready, exp));
		end
	endtask

	// Compare process that sees both handshakes as they complete on the edge
	always @(posedge clk) begin
		if (i_rst_n) begin
			if (exp_q.size() == ROUTE_DEPTH) begin
				check_ready(1'b0);	// Route FIFO full
			end else if (!stall_en && i_req_valid) begin
				check_ready(1'b1);	// One transfer per cycle while responses are always taken
			end
			if (o_rsp_valid && i_rsp_ready) begin
				if (exp_q.size() == 0) begin
					report_fail("response arrived with no request outstanding");
				end else begin
					check_rsp(o_rsp, exp_q.pop_front());
				end
			end
			if (i_req_valid && o_req_ready) exp_q.push_back(ref_rsp(i_req));
		end
	end

	// ******************************
	// Stimulus helpers
	// ******************************
	function automatic bus_req_t make_req(logic [31:0] addr, logic [31:0] data,
	                                      logic [3:0] strb, logic wr, logic [3:0] id);
		bus_req_t r;
		r.addr  = addr;
		r.wdata = data;
		r.wstrb = strb;
		r.write = wr;
		r.id    = id;
		return r;
	endfunction

	function automatic logic [31:0] err_addr();
		if ($urandom_range(0, 1) == 0) return 32'($urandom_range(0, SRAM_BASE - 1));
		return SRAM_END + 32'($urandom_range(0, 32'h0fff_ffff));
	endfunction

	function automatic bus_req_t rand_req();
		logic [31:0] a;
		case ($urandom_range(0, 3))
			0: return make_req(err_addr(), $urandom, 4'($urandom), 1'($urandom), 4'($urandom));
			1: begin
				a = SRAM_BASE + 32'($urandom_range(0, SRAM_WORDS - 1) * 4);
				known_q.push_back(a);	// Full strobe defines the whole word
				return make_req(a, $urandom, 4'hf, 1'b1, 4'($urandom));
			end
			2: begin
				a = known_q[$urandom_range(0, known_q.size() - 1)];
				return make_req(a, $urandom, 4'($urandom_range(1, 14)), 1'b1, 4'($urandom));
			end
			default: begin
				a = known_q[$urandom_range(0, known_q.size() - 1)] + $urandom_range(0, 3);
				return make_req(a, $urandom, 4'h0, 1'b0, 4'($urandom));
			end
		endcase
	endfunction

	// Called just after a rising edge and returns on the edge that takes the request
	task automatic drive_req(bus_req_t r);
		i_req_valid <= 1'b1;
		i_req       <= r;
		@(posedge clk);
		while (!o_req_ready) @(posedge clk);
		i_req_valid <= 1'b0;
		n_reqs++;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(posedge clk);
		@(posedge clk);
	endtask

	task automatic end_test(string name, int err_mark);
		$display("Test %s: %0d requests, %0d errors", name, n_reqs, errors - err_mark);
		n_reqs = 0;
	endtask

	// ******************************
	// Test sequence
	// ******************************
	initial begin
		int err_mark;
		void'($urandom(32'h6abb_d83b));
		i_rst_n     = 1'b0;
		i_req_valid = 1'b0;
		i_req       = '0;
		i_rsp_ready = 1'b0;
		fork
			forever begin
				@(posedge clk);
				i_rsp_ready <= stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
			end
		join_none
		repeat (16) @(posedge clk);
		i_rst_n <= 1'b1;
		@(posedge clk);

		err_mark = errors;
		check_ready(1'b1);
		if (o_rsp_valid !== 1'b0) report_fail("o_rsp_valid is high right after reset");
		for (int i = 0; i < N_WORDS; i++) begin
			known_q.push_back(SRAM_BASE + 32'(i) * 64);
			drive_req(make_req(known_q[i], $urandom, 4'hf, 1'b1, 4'(i)));
		end
		for (int i = 0; i < N_WORDS; i++) drive_req(make_req(known_q[i], '0, '0, 1'b0, 4'(i)));
		drain();
		end_test("write and read back", err_mark);

		err_mark = errors;
		for (int i = 0; i < N_WORDS; i++) begin
			drive_req(make_req(known_q[i], $urandom, 4'($urandom_range(1, 14)), 1'b1, 4'(i)));
		end
		for (int i = 0; i < N_WORDS; i++) drive_req(make_req(known_q[i], '0, '0, 1'b0, 4'(i)));
		drain();
		end_test("byte strobes", err_mark);

		err_mark = errors;
		for (int i = 0; i < N_ERR; i++) begin
			drive_req(make_req((i == 0) ? SRAM_BASE - 4 : (i == 1) ? SRAM_END : err_addr(),
			                   $urandom, 4'hf, 1'(i), 4'(i)));
		end
		for (int i = 0; i < N_WORDS; i++) drive_req(make_req(known_q[i], '0, '0, 1'b0, 4'(i)));
		drain();
		end_test("decode error", err_mark);

		err_mark = errors;
		for (int i = 0; i < N_RAND; i++) drive_req(rand_req());
		drain();
		end_test("mixed back-to-back", err_mark);

		err_mark = errors;
		stall_en = 1'b1;	// Random stalls on the response channel
		for (int i = 0; i < N_RAND; i++) drive_req(rand_req());
		drain();
		stall_en = 1'b0;
		end_test("back-pressure", err_mark);

		$display("Summary: %0d responses checked, %0d errors", n_checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog sized from the request count of all tests
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles with %0d responses still expected",
		         TIMEOUT_CYCLES, exp_q.size());
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: bench/mem_fabric_asserts.sv
// Valid/ready handshake and reset rules for the memory fabric top level.
// Bound onto mem_fabric_top, so every instance of the top level is checked.

module mem_fabric_asserts
	import bus_pkg::*;
(
	input logic     clk,
	input logic     i_rst_n,
	input logic     i_req_valid,
	input bus_req_t i_req,
	input logic     o_req_ready,
	input logic     o_rsp_valid,
	input bus_rsp_t o_rsp,
	input logic     i_rsp_ready
);

	// ******************************
	// Channel stability
	// ******************************
	req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_req_valid && !o_req_ready |=> i_req_valid && $stable(i_req))
		else $error("Request valid or payload changed while stalled");

	rsp_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
		else $error("Response valid or payload changed while stalled");

	// ******************************
	// Reset behavior
	// ******************************
	rsp_idle_in_reset: assert property (@(posedge clk) !i_rst_n |-> !o_rsp_valid)
		else $error("Response valid during reset");

	ready_after_reset: assert property (@(posedge clk) $rose(i_rst_n) |-> o_req_ready)
		else $error("Request ready low right after reset");	// Empty route FIFO

endmodule

bind mem_fabric_top mem_fabric_asserts i_mem_fabric_asserts (.*);

// File: mem_fabric.f
source/bus_pkg.sv
source/mem_map_pkg.sv
source/bus_interconnect_1x2.sv
source/sram_target.sv
source/decode_err_target.sv
source/mem_fabric_top.sv
bench/mem_fabric_tb.sv
bench/mem_fabric_asserts.sv
